// File: ecdhe_ctrl.f
src/ecdhe_pkg.sv
src/auc_pkg.sv
src/ecdhe_fsm.sv
src/beat_counter.sv
src/operand_store.sv
src/auc_tx.sv
src/result_store.sv
src/ecdhe_ctrl.sv
sim/ecdhe_ctrl_tb.sv

// File: Bender.yml
package:
  name: ecdhe_ctrl

sources:
  - src/ecdhe_pkg.sv
  - src/auc_pkg.sv
  - src/ecdhe_fsm.sv
  - src/beat_counter.sv
  - src/operand_store.sv
  - src/auc_tx.sv
  - src/result_store.sv
  - src/ecdhe_ctrl.sv
  - target: simulation
    files:
      - sim/ecdhe_ctrl_tb.sv

// File: sim/ecdhe_ctrl_tb.sv
// Directed testbench for the ECDHE controller with a behavioral AUC responder, run as top module
`timescale 1ns/100ps
`default_nettype none

module ecdhe_ctrl_tb;
    import ecdhe_pkg::*;
    import auc_pkg::*;

    localparam int TIMEOUT_CYC = 200;       // Cycles allowed for one result
    // u = 9 as little-endian bytes, first byte in the top bits
    localparam word_t BASE_U9 = word_t'(9) << (WORD_W - 8);

    // One scripted AUC answer per burst
    typedef struct packed {
        auc_status_t status;
        word_t       rslt;
    } auc_reply_t;

    logic        clk;
    logic        rst;
    host_req_t   req;
    host_rsp_t   rsp;
    auc_req_t    auc;
    word_t       auc_rslt;
    auc_status_t auc_status;

    auc_req_t    beat_q[$];                 // Beats seen on the AUC port
    auc_req_t    exp_q[$];                  // Beats the test expects
    auc_reply_t  reply_q[$];                // Answers, popped per burst
    int          err_cnt;
    int          test_cnt;

    ecdhe_ctrl dut_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp),
        .auc        (auc),
        .auc_rslt   (auc_rslt),
        .auc_status (auc_status)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;                  // 4 ns period
    end

    // ========================================
    // AUC responder
    // ========================================
    initial
    begin : auc_responder
        auc_reply_t  item;
        logic        in_burst;
        logic        pending;
        int unsigned delay;
        in_burst   = 1'b0;
        pending    = 1'b0;
        delay      = 0;
        auc_status = ST_IDLE;
        auc_rslt   = '0;
        forever
        begin
            @(negedge clk);                 // Sample mid cycle
            if (rst)
            begin
                in_burst = 1'b0;
                pending  = 1'b0;
            end
            else if (auc.start)
            begin
                beat_q.push_back(auc);
                in_burst = 1'b1;
            end
            else if (in_burst)
            begin
                in_burst = 1'b0;            // Burst just ended
                pending  = 1'b1;
                delay    = 2 + ($urandom % 19);
            end
            @(posedge clk);
            #0.5;
            auc_status = ST_IDLE;
            auc_rslt   = '0;
            if (pending && delay > 1)
            begin
                delay      = delay - 1;
                auc_status = ST_COMP;       // Still computing
            end
            else if (pending)
            begin
                pending = 1'b0;
                if (reply_q.size() == 0)
                begin
                    $display("AUC responder got a burst with no scripted answer");
                    err_cnt++;
                    auc_status = ST_DONE;
                end
                else
                begin
                    item       = reply_q.pop_front();
                    auc_status = item.status;
                    auc_rslt   = item.rslt;
                end
            end
        end
    end

    // ========================================
    // Helpers and compare tasks
    // ========================================
    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int i = 0; i < WORD_W / 32; i++)
            w = {w[WORD_W-33:0], 32'($urandom)};
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic word_equal(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic status_equal(input string name, input auc_status_t got,
                                input auc_status_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic op_equal(input string name, input auc_op_t got, input auc_op_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Recorded beat list against the expected one
    task automatic beats_equal(input string name);
        int n;
        if (beat_q.size() != exp_q.size())
        begin
            $display("Fail %s count: got 0x%h, expected 0x%h", name, beat_q.size(),
                     exp_q.size());
            err_cnt++;
        end
        n = (beat_q.size() < exp_q.size()) ? beat_q.size() : exp_q.size();
        for (int i = 0; i < n; i++)
        begin
            op_equal($sformatf("%s[%0d].op", name, i), beat_q[i].op, exp_q[i].op);
            word_equal($sformatf("%s[%0d].dat", name, i), beat_q[i].dat, exp_q[i].dat);
        end
    endtask

    task automatic clear_lists();
        beat_q.delete();
        exp_q.delete();
        reply_q.delete();
    endtask

    task automatic add_expected_beat(input auc_op_t op, input word_t dat);
        auc_req_t b;
        b.start = 1'b1;
        b.op    = op;
        b.dat   = dat;
        exp_q.push_back(b);
    endtask

    task automatic add_reply(input auc_status_t st, input word_t w);
        auc_reply_t r;
        r.status = st;
        r.rslt   = w;
        reply_q.push_back(r);
    endtask

    // One-cycle start, operands scrambled right after
    task automatic pulse_start(input host_op_t op, input word_t px, input word_t sc);
        @(posedge clk);
        #0.5;
        req.start  = 1'b1;
        req.op     = op;
        req.peer_x = px;
        req.scalar = sc;
        @(posedge clk);
        #0.5;
        req.start  = 1'b0;
        req.op     = OP_NONE;
        req.peer_x = random_word();
        req.scalar = random_word();
    endtask

    // Returns at the first negedge showing DONE or ERR
    task automatic wait_result(input string name);
        logic seen;
        seen = 1'b0;
        for (int cyc = 0; cyc < TIMEOUT_CYC && !seen; cyc++)
        begin
            @(negedge clk);
            seen = (rsp.status == ST_DONE) || (rsp.status == ST_ERR);
            // Busy status shows one cycle after the accepting edge
            if (!seen && cyc > 0)
            begin
                status_equal("rsp.status busy", auc_status_t'(rsp.status), ST_COMP);
                word_equal("rsp.dout busy", rsp.dout, '0);
            end
        end
        if (!seen)
            abort_run($sformatf("%s: no result from the controller in %0d cycles",
                                name, TIMEOUT_CYC));
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, err_cnt - errs_before);
    endtask

    // Key then public x on two cycles, then idle
    task automatic key_pair_check(input word_t key, input word_t pub);
        status_equal("rsp.status key", auc_status_t'(rsp.status), ST_DONE);
        word_equal("rsp.dout key", rsp.dout, key);
        @(negedge clk);
        status_equal("rsp.status pub", auc_status_t'(rsp.status), ST_DONE);
        word_equal("rsp.dout pub", rsp.dout, pub);
        @(negedge clk);
        status_equal("rsp.status end", auc_status_t'(rsp.status), ST_IDLE);
        word_equal("rsp.dout end", rsp.dout, '0);
        beats_equal("auc beats");
    endtask

    task automatic compute_secret(input string name, input logic poke_busy);
        word_t px;
        word_t sc;
        word_t secret;
        px     = random_word();
        sc     = random_word();
        secret = random_word();
        clear_lists();
        add_expected_beat(AUC_MMUL, '0);
        add_expected_beat(AUC_MMUL, word_t'(1));
        add_expected_beat(AUC_MMUL, px);
        add_expected_beat(AUC_MMUL, sc);
        add_reply(ST_DONE, secret);
        pulse_start(OP_COMP, px, sc);
        if (poke_busy)
        begin
            @(posedge clk);
            pulse_start(OP_GEN, random_word(), random_word());  // During burst
            pulse_start(OP_COMP, random_word(), random_word()); // During wait
        end
        wait_result(name);
        status_equal("rsp.status", auc_status_t'(rsp.status), ST_DONE);
        word_equal("rsp.dout", rsp.dout, secret);
        @(negedge clk);
        status_equal("rsp.status end", auc_status_t'(rsp.status), ST_IDLE);
        word_equal("rsp.dout end", rsp.dout, '0);
        beats_equal("auc beats");
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic idle_after_reset();
        int errs;
        errs = err_cnt;
        clear_lists();                      // No beat expected at all
        @(negedge clk);
        status_equal("rsp.status", auc_status_t'(rsp.status), ST_IDLE);
        word_equal("rsp.dout", rsp.dout, '0);
        word_equal("auc.dat", auc.dat, '0);
        pulse_start(OP_NONE, random_word(), random_word());
        pulse_start(host_op_t'(2'd3), random_word(), random_word());
        for (int cyc = 0; cyc < 10; cyc++)
        begin
            @(negedge clk);
            status_equal("rsp.status", auc_status_t'(rsp.status), ST_IDLE);
        end
        beats_equal("auc beats");
        report_test("idle after reset", errs);
    endtask

    task automatic keygen();
        int    errs;
        word_t key;
        word_t pub;
        errs = err_cnt;
        key  = random_word();
        pub  = random_word();
        clear_lists();
        add_expected_beat(AUC_RAND, '0);
        add_expected_beat(AUC_MMUL, '0);
        add_expected_beat(AUC_MMUL, word_t'(1));
        add_expected_beat(AUC_MMUL, BASE_U9);
        add_reply(ST_DONE, key);
        add_reply(ST_DONE, pub);
        pulse_start(OP_GEN, random_word(), random_word());
        wait_result("keygen");
        key_pair_check(key, pub);
        report_test("keygen", errs);
    endtask

    task automatic keygen_with_retry();
        int    errs;
        word_t key;
        word_t pub;
        errs = err_cnt;
        key  = random_word();
        pub  = random_word();
        clear_lists();
        for (int pass = 0; pass < 2; pass++)
        begin
            add_expected_beat(AUC_RAND, '0);
            add_expected_beat(AUC_MMUL, '0);
            add_expected_beat(AUC_MMUL, word_t'(1));
            add_expected_beat(AUC_MMUL, BASE_U9);
        end
        add_reply(ST_DONE, random_word());  // First key, dropped
        add_reply(ST_ERR, random_word());
        add_reply(ST_DONE, key);
        add_reply(ST_DONE, pub);
        pulse_start(OP_GEN, random_word(), random_word());
        wait_result("keygen retry");
        key_pair_check(key, pub);
        report_test("keygen retry", errs);
    endtask

    task automatic shared_secret();
        int errs;
        errs = err_cnt;
        compute_secret("shared secret", 1'b0);
        report_test("shared secret", errs);
    endtask

    task automatic secret_error();
        int    errs;
        word_t px;
        word_t sc;
        errs = err_cnt;
        px   = random_word();
        sc   = random_word();
        clear_lists();
        add_expected_beat(AUC_MMUL, '0);
        add_expected_beat(AUC_MMUL, word_t'(1));
        add_expected_beat(AUC_MMUL, px);
        add_expected_beat(AUC_MMUL, sc);
        add_reply(ST_ERR, random_word());
        pulse_start(OP_COMP, px, sc);
        wait_result("secret error");
        status_equal("rsp.status", auc_status_t'(rsp.status), ST_ERR);
        word_equal("rsp.dout", rsp.dout, '0);
        @(negedge clk);
        status_equal("rsp.status end", auc_status_t'(rsp.status), ST_IDLE);
        beats_equal("auc beats");
        compute_secret("secret after error", 1'b0);     // Next start still taken
        report_test("secret error", errs);
    endtask

    task automatic start_while_busy();
        int errs;
        errs = err_cnt;
        compute_secret("start while busy", 1'b1);
        report_test("start while busy", errs);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial
    begin
        void'($urandom(39575));
        err_cnt  = 0;
        test_cnt = 0;
        rst      = 1'b1;
        req      = '0;
        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b0;

        idle_after_reset();
        keygen();
        keygen_with_retry();
        shared_secret();
        secret_error();
        start_while_busy();

        $display("Tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/ecdhe_ctrl.sv
// Top of the ECDHE key-exchange controller, place between the host and the AUC
`timescale 1ns/100ps
`default_nettype none

module ecdhe_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  wire ecdhe_pkg::host_req_t req,
    output ecdhe_pkg::host_rsp_t      rsp,
    output auc_pkg::auc_req_t         auc,
    input  wire ecdhe_pkg::word_t     auc_rslt,
    input  wire auc_pkg::auc_status_t auc_status
);
    import ecdhe_pkg::*;

    // Burst control
    logic   launch;
    burst_t burst;
    beat_t  index;
    logic   last;
    logic   accept;

    // Operands and result strobes
    word_t  peer_x;
    word_t  scalar;
    logic   load_key;
    logic   show_key;
    logic   show_pub;
    logic   show_secret;
    logic   show_err;
    logic   busy;

    ecdhe_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .auc_status  (auc_status),
        .last        (last),
        .launch      (launch),
        .burst       (burst),
        .load_key    (load_key),
        .show_key    (show_key),
        .show_pub    (show_pub),
        .show_secret (show_secret),
        .show_err    (show_err),
        .busy        (busy),
        .accept      (accept)
    );

    beat_counter u_cnt (
        .clk    (clk),
        .rst    (rst),
        .launch (launch),
        .burst  (burst),
        .index  (index),
        .last   (last)
    );

    operand_store u_opnd (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .req    (req),
        .peer_x (peer_x),
        .scalar (scalar)
    );

    auc_tx u_tx (
        .clk    (clk),
        .rst    (rst),
        .launch (launch),
        .burst  (burst),
        .index  (index),
        .last   (last),
        .peer_x (peer_x),
        .scalar (scalar),
        .auc    (auc)
    );

    result_store u_rslt (
        .clk         (clk),
        .rst         (rst),
        .load_key    (load_key),
        .show_key    (show_key),
        .show_pub    (show_pub),
        .show_secret (show_secret),
        .show_err    (show_err),
        .busy        (busy),
        .auc_rslt    (auc_rslt),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

// File: src/result_store.sv
// Result register towards the host, keeps the private key and the public x
`timescale 1ns/100ps
`default_nettype none

module result_store (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   load_key,     // Random scalar on auc_rslt
    input  wire                   show_key,     // Public x on auc_rslt
    input  wire                   show_pub,
    input  wire                   show_secret,  // Secret on auc_rslt
    input  wire                   show_err,
    input  wire                   busy,
    input  wire ecdhe_pkg::word_t auc_rslt,
    output ecdhe_pkg::host_rsp_t  rsp
);
    import ecdhe_pkg::*;
    import auc_pkg::*;

    word_t key;                             // Private scalar
    word_t pub;                             // Public x, shown one cycle late

    always_ff @(posedge clk)
    begin
        if (load_key)
            key <= auc_rslt;
        if (show_key)
            pub <= auc_rslt;                // Same DONE cycle as the key strobe
    end

    // ========================================
    // Host response
    // ========================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rsp.dout   <= '0;
            rsp.status <= ST_IDLE;
        end
        else if (show_err)
        begin
            rsp.dout   <= '0;
            rsp.status <= ST_ERR;
        end
        else if (show_key)
        begin
            rsp.dout   <= key;              // First word of the key pair
            rsp.status <= ST_DONE;
        end
        else if (show_pub)
        begin
            rsp.dout   <= pub;
            rsp.status <= ST_DONE;
        end
        else if (show_secret)
        begin
            rsp.dout   <= auc_rslt;         // Straight from the AUC
            rsp.status <= ST_DONE;
        end
        else
        begin
            rsp.dout   <= '0;
            rsp.status <= busy ? ST_COMP : ST_IDLE;
        end
    end

endmodule

`default_nettype wire

// File: src/auc_tx.sv
// AUC request register, sends one beat per cycle while a burst runs
`timescale 1ns/100ps
`default_nettype none

module auc_tx (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    launch,
    input  wire ecdhe_pkg::burst_t burst,
    input  wire ecdhe_pkg::beat_t  index,
    input  wire                    last,
    input  wire ecdhe_pkg::word_t  peer_x,
    input  wire ecdhe_pkg::word_t  scalar,
    output auc_pkg::auc_req_t      auc
);
    import ecdhe_pkg::*;
    import auc_pkg::*;

    logic   run;                            // Burst in progress
    burst_t cur_burst;                      // Kept from launch
    word_t  beat_word;

    // ========================================
    // Data word for the current beat
    // ========================================
    always_comb
    begin
        case (index)
            2'd0:    beat_word = '0;        // Ladder start value
            2'd1:    beat_word = word_t'(1);
            2'd2:    beat_word = (cur_burst == BURST_GEN) ? X25519_BASE : peer_x;
            default: beat_word = scalar;
        endcase
        if (cur_burst == BURST_RAND)
            beat_word = '0;                 // Random request has no operand
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run       <= 1'b0;
            cur_burst <= BURST_RAND;
            auc       <= '0;
        end
        else
        begin
            if (launch)
            begin
                run       <= 1'b1;
                cur_burst <= burst;
            end
            else if (run && last)
                run <= 1'b0;                // Final beat goes out now

            if (run)
            begin
                auc.start <= 1'b1;
                auc.op    <= (cur_burst == BURST_RAND) ? AUC_RAND : AUC_MMUL;
                auc.dat   <= beat_word;
            end
            else
            begin
                auc.start <= 1'b0;
                auc.dat   <= '0;            // Op kept from last burst
            end
        end
    end

endmodule

`default_nettype wire

// File: src/operand_store.sv
// Holds the host operands of a shared-secret command for the length of the operation
`timescale 1ns/100ps
`default_nettype none

module operand_store (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       accept,   // Command taken this cycle
    input  wire ecdhe_pkg::host_req_t req,
    output ecdhe_pkg::word_t          peer_x,
    output ecdhe_pkg::word_t          scalar
);

    // Host may change its bus once the command is taken
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            peer_x <= '0;
            scalar <= '0;
        end
        else if (accept)
        begin
            peer_x <= req.peer_x;           // Beat 2 of the compute burst
            scalar <= req.scalar;           // Beat 3
        end
    end

endmodule

`default_nettype wire

// File: src/beat_counter.sv
// Beat counter for one AUC burst, flags the final beat for the FSM and the sender
`timescale 1ns/100ps
`default_nettype none

module beat_counter (
    input  wire                clk,
    input  wire                rst,
    input  wire                launch,
    input  wire ecdhe_pkg::burst_t burst,
    output ecdhe_pkg::beat_t   index,       // 0 the cycle after launch
    output logic               last
);
    import ecdhe_pkg::*;

    beat_t cnt;
    beat_t end_idx;                         // Index of the final beat
    beat_t end_load;
    logic  run;

    // Burst length minus one
    always_comb
    begin
        case (burst)
            BURST_GEN:  end_load = beat_t'(GEN_BEATS - 1);
            BURST_COMP: end_load = beat_t'(COMP_BEATS - 1);
            default:    end_load = '0;      // Random request is a single beat
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run     <= 1'b0;
            cnt     <= '0;
            end_idx <= '0;
        end
        else if (launch)
        begin
            run     <= 1'b1;
            cnt     <= '0;
            end_idx <= end_load;
        end
        else if (run)
        begin
            if (last)
                run <= 1'b0;                // Hold after final beat
            else
                cnt <= cnt + 2'd1;
        end
    end

    assign index = cnt;
    assign last  = run && (cnt == end_idx);

endmodule

`default_nettype wire

// File: src/ecdhe_fsm.sv
// Operation FSM of the ECDHE controller, turns host commands and AUC status into strobes
`timescale 1ns/100ps
`default_nettype none

module ecdhe_fsm (
    input  wire                       clk,
    input  wire                       rst,
    input  wire ecdhe_pkg::host_req_t req,
    input  wire auc_pkg::auc_status_t auc_status,
    input  wire                       last,         // Final beat of current burst
    output logic                      launch,       // Load counter and sender
    output ecdhe_pkg::burst_t         burst,        // Valid with launch
    output logic                      load_key,     // Capture random scalar
    output logic                      show_key,
    output logic                      show_pub,
    output logic                      show_secret,
    output logic                      show_err,
    output logic                      busy,
    output logic                      accept        // Command taken this cycle
);
    import ecdhe_pkg::*;
    import auc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        RAND_TX,                            // Random beat on its way
        RAND_WAIT,
        GEN_TX,                             // Base point multiply burst
        GEN_WAIT,
        GEN_PUB,                            // Second result word
        COMP_TX,                            // Peer multiply burst
        COMP_WAIT
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   auc_done;
    logic   auc_err;
    logic   op_ok;

    assign auc_done = (auc_status == ST_DONE);
    assign auc_err  = (auc_status == ST_ERR);
    assign op_ok    = (req.op == OP_GEN) || (req.op == OP_COMP);
    assign accept   = (state == IDLE) && req.start && op_ok;

    assign busy     = (state != IDLE);
    assign show_pub = (state == GEN_PUB);   // One cycle behind show_key

    // ========================================
    // Next state and strobes
    // ========================================
    always_comb
    begin
        state_nxt   = state;
        launch      = 1'b0;
        burst       = BURST_RAND;
        load_key    = 1'b0;
        show_key    = 1'b0;
        show_secret = 1'b0;
        show_err    = 1'b0;
        case (state)
            IDLE:
                if (accept)
                begin
                    launch = 1'b1;
                    if (req.op == OP_COMP)
                    begin
                        burst     = BURST_COMP;     // Scalar comes from host
                        state_nxt = COMP_TX;
                    end
                    else
                        state_nxt = RAND_TX;        // Draw private key first
                end
            RAND_TX:
                if (last)
                    state_nxt = RAND_WAIT;
            RAND_WAIT:
                if (auc_done)
                begin
                    load_key  = 1'b1;
                    launch    = 1'b1;
                    burst     = BURST_GEN;
                    state_nxt = GEN_TX;
                end
                else if (auc_err)
                begin
                    launch    = 1'b1;               // Ask again
                    state_nxt = RAND_TX;
                end
            GEN_TX:
                if (last)
                    state_nxt = GEN_WAIT;
            GEN_WAIT:
                if (auc_done)
                begin
                    show_key  = 1'b1;               // Public x stored alongside
                    state_nxt = GEN_PUB;
                end
                else if (auc_err)
                begin
                    launch    = 1'b1;               // Restart with a fresh scalar
                    state_nxt = RAND_TX;
                end
            GEN_PUB:
                state_nxt = IDLE;
            COMP_TX:
                if (last)
                    state_nxt = COMP_WAIT;
            COMP_WAIT:
                if (auc_done)
                begin
                    show_secret = 1'b1;
                    state_nxt   = IDLE;
                end
                else if (auc_err)
                begin
                    show_err  = 1'b1;               // No retry for host operands
                    state_nxt = IDLE;
                end
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

endmodule

`default_nettype wire

// File: src/auc_pkg.sv
// Command and status types of the AUC link, compiled after the ECDHE package
`default_nettype none

package auc_pkg;

    // ========================================
    // AUC command codes
    // ========================================
    typedef enum logic [2:0] {
        AUC_RAND = 3'd0,                    // Random scalar, also kept inside the AUC
        AUC_MMUL = 3'd5                     // Montgomery ladder multiply
    } auc_op_t;

    // Same encoding on the host status port
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_COMP = 2'd1,                     // Operation in progress
        ST_DONE = 2'd2,                     // Result valid this cycle
        ST_ERR  = 2'd3                      // Operation failed
    } auc_status_t;

    // One data beat towards the AUC
    typedef struct packed {
        logic             start;            // High once per beat
        auc_op_t          op;               // Constant over a burst
        ecdhe_pkg::word_t dat;
    } auc_req_t;

endpackage

`default_nettype wire

// File: src/ecdhe_pkg.sv
// Types and constants for the ECDHE controller and its host port, imported where used
`default_nettype none

package ecdhe_pkg;

    // ========================================
    // Field elements and curve constants
    // ========================================
    localparam int WORD_W = 256;            // One X25519 field element

    typedef logic [WORD_W-1:0] word_t;      // Field element or scalar
    typedef logic [1:0]        beat_t;      // Beat index inside one burst
    typedef logic [1:0]        host_status_t; // Carries auc_pkg::auc_status_t codes

    // Base point u = 9, least significant byte first as the AUC expects
    localparam word_t X25519_BASE = {8'h09, {(WORD_W-8){1'b0}}};

    localparam int GEN_BEATS  = 3;          // 0, 1, base point
    localparam int COMP_BEATS = 4;          // 0, 1, peer x, scalar

    // ========================================
    // Host command set and internal selectors
    // ========================================
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_GEN  = 2'd1,                     // Key pair generation
        OP_COMP = 2'd2                      // Shared secret from peer x
    } host_op_t;                            // Code 3 never accepted

    typedef enum logic [1:0] {
        BURST_RAND,                         // Single random scalar request
        BURST_GEN,                          // Multiply by base point
        BURST_COMP                          // Multiply peer x by host scalar
    } burst_t;

    typedef struct packed {
        logic     start;                    // One-cycle command pulse
        host_op_t op;
        word_t    peer_x;                   // Sampled in the accepting cycle
        word_t    scalar;
    } host_req_t;

    typedef struct packed {
        word_t        dout;                 // Zero unless status is DONE
        host_status_t status;
    } host_rsp_t;

endpackage

`default_nettype wire
